/* filelist.f */
common/lsu_pkg.sv
common/dcache_if.sv
common/mmu_if.sv
rtl/lsu.sv
rtl/dtlb.sv
dcache/dcache.sv
rtl/mem_subsys_top.sv
sim/tb_clock.sv
sim/wb_mem_model.sv
sim/tb_mem_subsys.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_mem_subsys
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

  // About 700 accesses at up to 12 cycles each, with margin
  localparam int TIMEOUT_CYCLES = 20000;

  localparam lsu_pkg::tag_t VP_A = 20'h10000;
  localparam lsu_pkg::tag_t VP_B = 20'h10001;
  localparam lsu_pkg::tag_t VP_U = 20'h20000;
  localparam lsu_pkg::tag_t VP_X = 20'h30000;
  localparam lsu_pkg::tag_t PP_A = 20'h00001;
  localparam lsu_pkg::tag_t PP_B = 20'h00002;
  localparam lsu_pkg::tag_t PP_U = 20'h00003;
  localparam lsu_pkg::tag_t PP_X = 20'h00004;

  logic                 clk;
  logic                 reset;
  logic                 valid;
  logic                 ready;
  lsu_pkg::word_t       addr;
  lsu_pkg::mem_opcode_t opcode;
  lsu_pkg::word_t       st_data;
  logic                 have_excp;
  lsu_pkg::excp_t       excp_type;
  logic                 ok;
  lsu_pkg::word_t       ld_data;
  lsu_pkg::plv_t        plv;
  logic                 tlb_we;
  lsu_pkg::tlb_idx_t    tlb_idx;
  lsu_pkg::tag_t        tlb_vtag;
  lsu_pkg::tag_t        tlb_ptag;
  lsu_pkg::mat_t        tlb_mat;
  logic                 tlb_v;
  logic                 tlb_d;
  lsu_pkg::plv_t        tlb_plv;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  lsu_pkg::word_t       wb_adr;
  logic [3:0]           wb_sel;
  lsu_pkg::word_t       wb_dat_w;
  lsu_pkg::word_t       wb_dat_r;
  logic                 wb_ack;

  lsu_pkg::word_t shadow [4096];
  int             errors;
  int             checks;
  int             cycles;
  int             seed;

  tb_clock u_clock (.clk(clk));

  mem_subsys_top u_dut (
    .clk(clk), .reset(reset), .valid(valid), .ready(ready), .addr(addr),
    .opcode(opcode), .st_data(st_data), .have_excp(have_excp),
    .excp_type(excp_type), .ok(ok), .ld_data(ld_data), .plv(plv),
    .tlb_we(tlb_we), .tlb_idx(tlb_idx), .tlb_vtag(tlb_vtag), .tlb_ptag(tlb_ptag),
    .tlb_mat(tlb_mat), .tlb_v(tlb_v), .tlb_d(tlb_d), .tlb_plv(tlb_plv),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  wb_mem_model u_mem (
    .clk(clk), .reset(reset), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we),
    .adr(wb_adr), .sel(wb_sel), .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack)
  );

  // Word slot in the memory model for a virtual address
  function automatic int word_index(input lsu_pkg::word_t va);
    lsu_pkg::tag_t pp;
    case (va[31:12])
      VP_A:    pp = PP_A;
      VP_B:    pp = PP_B;
      VP_U:    pp = PP_U;
      default: pp = PP_X;
    endcase
    return int'({pp[1:0], va[11:2]});
  endfunction

  function automatic lsu_pkg::word_t load_value(input lsu_pkg::mem_opcode_t op,
                                                input lsu_pkg::word_t w,
                                                input logic [1:0] off);
    lsu_pkg::word_t sh;
    sh = w >> (8 * off);
    case (op)
      lsu_pkg::LD_B:  return lsu_pkg::word_t'($signed(sh[7:0]));
      lsu_pkg::LD_BU: return sh & 32'h0000_00ff;
      lsu_pkg::LD_H:  return lsu_pkg::word_t'($signed(sh[15:0]));
      lsu_pkg::LD_HU: return sh & 32'h0000_ffff;
      default:        return w;
    endcase
  endfunction

  function automatic logic is_store(input lsu_pkg::mem_opcode_t op);
    return op inside {lsu_pkg::ST_B, lsu_pkg::ST_H, lsu_pkg::ST_W};
  endfunction

  task automatic store_shadow(input lsu_pkg::mem_opcode_t op, input lsu_pkg::word_t va,
                              input lsu_pkg::word_t data);
    int             idx;
    lsu_pkg::word_t mask;
    idx = word_index(va);
    case (op)
      lsu_pkg::ST_B: mask = 32'h0000_00ff << (8 * va[1:0]);
      lsu_pkg::ST_H: mask = 32'h0000_ffff << (8 * va[1:0]);
      default:       mask = 32'hffff_ffff;
    endcase
    shadow[idx] = (shadow[idx] & ~mask) | ((data << (8 * va[1:0])) & mask);
  endtask

  task automatic check(input string name, input lsu_pkg::word_t expected,
                       input lsu_pkg::word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic tlb_write(input lsu_pkg::tlb_idx_t idx, input lsu_pkg::tag_t vtag,
                           input lsu_pkg::tag_t ptag, input lsu_pkg::mat_t mat,
                           input logic v, input logic d, input lsu_pkg::plv_t eplv);
    @(posedge clk);
    #1;
    tlb_we   = 1'b1;
    tlb_idx  = idx;
    tlb_vtag = vtag;
    tlb_ptag = ptag;
    tlb_mat  = mat;
    tlb_v    = v;
    tlb_d    = d;
    tlb_plv  = eplv;
    @(posedge clk);
    #1;
    tlb_we = 1'b0;
  endtask

  task automatic set_plv(input lsu_pkg::plv_t p);
    @(posedge clk);
    #1;
    plv = p;
  endtask

  // Holds the request until it transfers or raises an exception
  task automatic do_access(input lsu_pkg::mem_opcode_t op, input lsu_pkg::word_t va,
                           input lsu_pkg::word_t wd, output logic excp,
                           output lsu_pkg::excp_t etype, output lsu_pkg::word_t rd);
    excp  = 1'b0;
    etype = lsu_pkg::ALE;
    rd    = '0;
    @(posedge clk);
    #1;
    valid   = 1'b1;
    addr    = va;
    opcode  = op;
    st_data = wd;
    @(negedge clk);
    while (!have_excp && !ready) begin
      @(negedge clk);
    end
    if (have_excp) begin
      excp  = 1'b1;
      etype = excp_type;
    end
    @(posedge clk);
    #1;
    valid = 1'b0;
    if (!excp) begin
      @(negedge clk);
      while (!ok) begin
        @(negedge clk);
      end
      rd = ld_data;
    end
  endtask

  task automatic run_load(input string name, input lsu_pkg::mem_opcode_t op,
                          input lsu_pkg::word_t va);
    logic           excp;
    lsu_pkg::excp_t etype;
    lsu_pkg::word_t rd;
    do_access(op, va, '0, excp, etype, rd);
    if (excp) begin
      errors++;
      $display("Unexpected exception %s in %s", etype.name(), name);
    end else begin
      check(name, load_value(op, shadow[word_index(va)], va[1:0]), rd);
    end
  endtask

  task automatic run_store(input string name, input lsu_pkg::mem_opcode_t op,
                           input lsu_pkg::word_t va, input lsu_pkg::word_t data);
    logic           excp;
    lsu_pkg::excp_t etype;
    lsu_pkg::word_t rd;
    do_access(op, va, data, excp, etype, rd);
    if (excp) begin
      errors++;
      $display("Unexpected exception %s in %s", etype.name(), name);
    end else begin
      store_shadow(op, va, data);
    end
  endtask

  task automatic expect_excp(input string name, input lsu_pkg::mem_opcode_t op,
                             input lsu_pkg::word_t va, input lsu_pkg::excp_t expected);
    logic           excp;
    lsu_pkg::excp_t etype;
    lsu_pkg::word_t rd;
    int             bus0;
    bus0 = u_mem.rd_count + u_mem.wr_count;
    do_access(op, va, 32'h0bad_0bad, excp, etype, rd);
    if (!excp) begin
      errors++;
      $display("No exception raised in %s, expected %s", name, expected.name());
    end else begin
      check(name, lsu_pkg::word_t'(expected), lsu_pkg::word_t'(etype));
    end
    // A request taken by the cache starts its bus cycle one cycle later
    repeat (2) @(posedge clk);
    #1;
    check({name, " bus cycles"}, lsu_pkg::word_t'(bus0),
          lsu_pkg::word_t'(u_mem.rd_count + u_mem.wr_count));
  endtask

  task automatic check_model_word(input string name, input lsu_pkg::word_t va);
    check(name, shadow[word_index(va)], u_mem.mem[word_index(va)]);
  endtask

  task automatic load_all_lanes(input string name, input lsu_pkg::word_t word_va);
    for (int o = 0; o < 4; o++) begin
      run_load($sformatf("%s ld_b +%0d", name, o), lsu_pkg::LD_B, word_va + o);
      run_load($sformatf("%s ld_bu +%0d", name, o), lsu_pkg::LD_BU, word_va + o);
      if (o % 2 == 0) begin
        run_load($sformatf("%s ld_h +%0d", name, o), lsu_pkg::LD_H, word_va + o);
        run_load($sformatf("%s ld_hu +%0d", name, o), lsu_pkg::LD_HU, word_va + o);
      end
    end
  endtask

  task automatic cached_word_access();
    lsu_pkg::word_t va;
    int             rd0;
    int             wr0;
    va  = {VP_A, 12'h100};
    wr0 = u_mem.wr_count;
    run_store("cached st_w", lsu_pkg::ST_W, va, 32'hcafe_f00d);
    check("cached st_w bus writes", lsu_pkg::word_t'(wr0 + 1),
          lsu_pkg::word_t'(u_mem.wr_count));
    run_load("cached ld_w first", lsu_pkg::LD_W, va);
    rd0 = u_mem.rd_count;
    run_load("cached ld_w second", lsu_pkg::LD_W, va);
    check("cached ld_w second bus reads", lsu_pkg::word_t'(rd0),
          lsu_pkg::word_t'(u_mem.rd_count));
  endtask

  task automatic subword_access();
    lsu_pkg::word_t base;
    lsu_pkg::word_t va;
    base = {VP_A, 12'h200};
    // Only the first word is in the cache before its stores
    run_load("subword prefill", lsu_pkg::LD_W, base);
    for (int w = 0; w < 2; w++) begin
      va = base + 4 * w;
      for (int b = 0; b < 4; b++) begin
        run_store($sformatf("subword st_b +%0d", b), lsu_pkg::ST_B, va + b,
                  32'h8d + 32'h47 * b + w);
      end
      check_model_word("subword model after st_b", va);
      load_all_lanes("subword after st_b", va);
      run_store("subword st_h +0", lsu_pkg::ST_H, va, 32'h0000_8123 + w);
      run_store("subword st_h +2", lsu_pkg::ST_H, va + 2, 32'h0000_7e45 + w);
      check_model_word("subword model after st_h", va);
      load_all_lanes("subword after st_h", va);
    end
  endtask

  task automatic uncached_page();
    lsu_pkg::word_t va_u;
    lsu_pkg::word_t va_c;
    lsu_pkg::word_t old;
    int             rd0;
    va_u = {VP_U, 12'h040};
    va_c = {VP_A, 12'h100};
    for (int i = 0; i < 2; i++) begin
      rd0 = u_mem.rd_count;
      run_load("uncached ld_w", lsu_pkg::LD_W, va_u);
      check("uncached ld_w bus reads", lsu_pkg::word_t'(rd0 + 1),
            lsu_pkg::word_t'(u_mem.rd_count));
    end
    run_store("uncached st_h", lsu_pkg::ST_H, va_u + 2, 32'h0000_e6a1);
    run_load("uncached ld_hu after st_h", lsu_pkg::LD_HU, va_u + 2);
    // Change memory behind the cache
    old = shadow[word_index(va_c)];
    u_mem.mem[word_index(va_c)] = ~old;
    u_mem.mem[word_index(va_u)] = 32'h1234_abcd;
    shadow[word_index(va_u)]    = 32'h1234_abcd;
    run_load("uncached ld_w sees new value", lsu_pkg::LD_W, va_u);
    run_load("cached ld_w keeps old copy", lsu_pkg::LD_W, va_c);
    u_mem.mem[word_index(va_c)] = old;
  endtask

  task automatic alignment_faults();
    expect_excp("ale ld_h", lsu_pkg::LD_H, {VP_A, 12'h301}, lsu_pkg::ALE);
    expect_excp("ale ld_hu", lsu_pkg::LD_HU, {VP_A, 12'h303}, lsu_pkg::ALE);
    expect_excp("ale ld_w", lsu_pkg::LD_W, {VP_A, 12'h302}, lsu_pkg::ALE);
    expect_excp("ale st_h", lsu_pkg::ST_H, {VP_U, 12'h305}, lsu_pkg::ALE);
    expect_excp("ale st_w", lsu_pkg::ST_W, {VP_B, 12'h301}, lsu_pkg::ALE);
    expect_excp("ale unmapped", lsu_pkg::LD_W, 32'h7654_3213, lsu_pkg::ALE);
  endtask

  task automatic translation_faults();
    lsu_pkg::word_t va;
    va = {VP_X, 12'h010};
    expect_excp("tlbr load", lsu_pkg::LD_W, 32'h5555_5000, lsu_pkg::D_TLBR);
    expect_excp("tlbr store", lsu_pkg::ST_B, 32'h5555_5001, lsu_pkg::D_TLBR);
    tlb_write(2'd3, VP_X, PP_X, 2'd1, 1'b0, 1'b1, 2'd3);
    expect_excp("pil", lsu_pkg::LD_W, va, lsu_pkg::PIL);
    expect_excp("pis", lsu_pkg::ST_W, va, lsu_pkg::PIS);
    tlb_write(2'd3, VP_X, PP_X, 2'd1, 1'b1, 1'b1, 2'd0);
    set_plv(2'd1);
    expect_excp("ppi", lsu_pkg::LD_B, va, lsu_pkg::PPI);
    set_plv(2'd0);
    run_load("load at plv 0", lsu_pkg::LD_W, va);
    tlb_write(2'd3, VP_X, PP_X, 2'd1, 1'b1, 1'b0, 2'd3);
    expect_excp("pme", lsu_pkg::ST_H, va, lsu_pkg::PME);
    run_load("load from clean page", lsu_pkg::LD_H, va + 2);
    // Several faults on one page
    tlb_write(2'd3, VP_X, PP_X, 2'd1, 1'b0, 1'b0, 2'd0);
    set_plv(2'd1);
    expect_excp("pis over ppi and pme", lsu_pkg::ST_W, va, lsu_pkg::PIS);
    expect_excp("pil over ppi", lsu_pkg::LD_W, va, lsu_pkg::PIL);
    tlb_write(2'd3, VP_X, PP_X, 2'd1, 1'b1, 1'b0, 2'd0);
    expect_excp("ppi over pme", lsu_pkg::ST_B, va, lsu_pkg::PPI);
    expect_excp("ale over tlb faults", lsu_pkg::ST_W, va + 2, lsu_pkg::ALE);
    set_plv(2'd0);
  endtask

  task automatic random_mix();
    lsu_pkg::mem_opcode_t op;
    lsu_pkg::tag_t        vp;
    lsu_pkg::word_t       va;
    lsu_pkg::word_t       data;
    int                   r;
    for (int n = 0; n < 600; n++) begin
      r  = $random(seed);
      op = lsu_pkg::mem_opcode_t'(r[2:0]);
      case (r[4:3])
        2'd1:    vp = VP_B;
        2'd2:    vp = VP_U;
        default: vp = VP_A;
      endcase
      // 64 words per page, so pages A and B share cache lines
      va = {vp, 4'h0, r[10:5], r[12:11]};
      if (op inside {lsu_pkg::LD_H, lsu_pkg::LD_HU, lsu_pkg::ST_H}) begin
        va[0] = 1'b0;
      end
      if (op inside {lsu_pkg::LD_W, lsu_pkg::ST_W}) begin
        va[1:0] = 2'b00;
      end
      data = $random(seed);
      if (is_store(op)) begin
        run_store($sformatf("random %0d %s", n, op.name()), op, va, data);
      end else begin
        run_load($sformatf("random %0d %s", n, op.name()), op, va);
      end
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, checks: %0d, errors: %0d",
               TIMEOUT_CYCLES, checks, errors);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    errors   = 0;
    checks   = 0;
    cycles   = 0;
    seed     = 32'he401_d5df;
    reset    = 1'b1;
    valid    = 1'b0;
    addr     = '0;
    opcode   = lsu_pkg::LD_W;
    st_data  = '0;
    plv      = 2'd0;
    tlb_we   = 1'b0;
    tlb_idx  = '0;
    tlb_vtag = '0;
    tlb_ptag = '0;
    tlb_mat  = '0;
    tlb_v    = 1'b0;
    tlb_d    = 1'b0;
    tlb_plv  = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < 4096; i++) begin
      shadow[i] = u_mem.mem[i];
    end
    tlb_write(2'd0, VP_A, PP_A, 2'd1, 1'b1, 1'b1, 2'd3);
    tlb_write(2'd1, VP_B, PP_B, 2'd1, 1'b1, 1'b1, 2'd3);
    tlb_write(2'd2, VP_U, PP_U, 2'd0, 1'b1, 1'b1, 2'd3);
    cached_word_access();
    subword_access();
    uncached_page();
    alignment_faults();
    translation_faults();
    random_mix();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* sim/wb_mem_model.sv */
`timescale 1ns/1ps

module wb_mem_model (
  input  logic        clk,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [3:0]  sel,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack
);

  logic [31:0] mem [4096];
  logic [11:0] idx;
  int          rd_count;
  int          wr_count;

  assign idx = adr[13:2];

  // Every word gets a value that depends on its full word address
  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    end
  end

  // One ack per cycle, raised the cycle after stb is seen
  always @(posedge clk) begin
    if (reset) begin
      ack      <= 1'b0;
      rd_count <= 0;
      wr_count <= 0;
    end else begin
      ack <= 1'b0;
      if (cyc && stb && !ack) begin
        ack <= 1'b1;
        if (we) begin
          for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
              mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
            end
          end
          wr_count <= wr_count + 1;
        end else begin
          dat_r    <= mem[idx];
          rd_count <= rd_count + 1;
        end
      end
    end
  end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 4 ns period
  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

endmodule

/* rtl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 valid,
  output logic                 ready,
  input  lsu_pkg::word_t       addr,
  input  lsu_pkg::mem_opcode_t opcode,
  input  lsu_pkg::word_t       st_data,
  output logic                 have_excp,
  output lsu_pkg::excp_t       excp_type,
  output logic                 ok,
  output lsu_pkg::word_t       ld_data,
  input  lsu_pkg::plv_t        plv,
  input  logic                 tlb_we,
  input  lsu_pkg::tlb_idx_t    tlb_idx,
  input  lsu_pkg::tag_t        tlb_vtag,
  input  lsu_pkg::tag_t        tlb_ptag,
  input  lsu_pkg::mat_t        tlb_mat,
  input  logic                 tlb_v,
  input  logic                 tlb_d,
  input  lsu_pkg::plv_t        tlb_plv,
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic                 wb_we,
  output lsu_pkg::word_t       wb_adr,
  output logic [3:0]           wb_sel,
  output lsu_pkg::word_t       wb_dat_w,
  input  lsu_pkg::word_t       wb_dat_r,
  input  logic                 wb_ack
);

  mmu_if    u_mmu_if ();
  dcache_if u_dcache_if ();

  lsu u_lsu (
    .clk       (clk),
    .reset     (reset),
    .valid     (valid),
    .ready     (ready),
    .addr      (addr),
    .opcode    (opcode),
    .st_data   (st_data),
    .have_excp (have_excp),
    .excp_type (excp_type),
    .ok        (ok),
    .ld_data   (ld_data),
    .mmu       (u_mmu_if.lsu),
    .cache     (u_dcache_if.lsu)
  );

  dtlb u_dtlb (
    .clk    (clk),
    .reset  (reset),
    .plv    (plv),
    .we     (tlb_we),
    .w_idx  (tlb_idx),
    .w_vtag (tlb_vtag),
    .w_ptag (tlb_ptag),
    .w_mat  (tlb_mat),
    .w_v    (tlb_v),
    .w_d    (tlb_d),
    .w_plv  (tlb_plv),
    .mmu    (u_mmu_if.tlb)
  );

  dcache u_dcache (
    .clk      (clk),
    .reset    (reset),
    .req      (u_dcache_if.cache),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_sel   (wb_sel),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

endmodule

/* dcache/dcache.sv */
`timescale 1ns/1ps

module dcache (
  input  logic           clk,
  input  logic           reset,
  dcache_if.cache        req,
  output logic           wb_cyc,
  output logic           wb_stb,
  output logic           wb_we,
  output lsu_pkg::word_t wb_adr,
  output logic [3:0]     wb_sel,
  output lsu_pkg::word_t wb_dat_w,
  input  lsu_pkg::word_t wb_dat_r,
  input  logic           wb_ack
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOOKUP,
    S_BUS
  } state_t;

  state_t                                 state;
  lsu_pkg::word_t                         data_mem [1 << lsu_pkg::INDEX_WIDTH];
  lsu_pkg::tag_t                          tag_mem  [1 << lsu_pkg::INDEX_WIDTH];
  logic [(1 << lsu_pkg::INDEX_WIDTH)-1:0] line_valid;
  lsu_pkg::word_t                         rdata_q;
  logic                                   fill_q;
  logic                                   accept;
  logic                                   hit;
  logic                                   bus_done;
  lsu_pkg::word_t                         merged;
  lsu_pkg::index_t                        fill_index;
  lsu_pkg::tag_t                          fill_tag;

  // The tag compare happens in the accepting cycle, the lookup state
  // then returns the result and can already take the next request
  assign req.data_ok = (state == S_LOOKUP);
  assign req.addr_ok = (state != S_BUS);
  assign req.rdata   = rdata_q;

  assign accept   = req.valid && req.addr_ok;
  assign hit      = line_valid[req.index] && (tag_mem[req.index] == req.tag);
  assign bus_done = (state == S_BUS) && wb_ack;

  // Read addresses are word aligned, so the line sits in the bus address
  assign fill_index = wb_adr[lsu_pkg::OFFSET_WIDTH +: lsu_pkg::INDEX_WIDTH];
  assign fill_tag   = wb_adr[31 -: lsu_pkg::TAG_WIDTH];

  always_comb begin
    merged = data_mem[req.index];
    for (int b = 0; b < 4; b++) begin
      if (req.wstrb[b]) begin
        merged[8*b +: 8] = req.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= S_IDLE;
      wb_cyc     <= 1'b0;
      wb_stb     <= 1'b0;
      fill_q     <= 1'b0;
      line_valid <= '0;
    end else begin
      case (state)
        S_IDLE, S_LOOKUP: begin
          if (accept && !req.we && !req.uncached && hit) begin
            state <= S_LOOKUP;
          end else if (accept) begin
            state  <= S_BUS;
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            fill_q <= !req.we && !req.uncached;
          end else begin
            state <= S_IDLE;
          end
        end
        S_BUS: begin
          if (wb_ack) begin
            state  <= S_LOOKUP;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            if (fill_q) begin
              line_valid[fill_index] <= 1'b1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wb_we    <= req.we;
      wb_adr   <= {req.tag, req.index, req.we ? req.offset : lsu_pkg::offset_t'(0)};
      wb_sel   <= req.we ? req.wstrb : 4'b1111;
      wb_dat_w <= req.wdata;
      rdata_q  <= data_mem[req.index];
    end else if (bus_done) begin
      rdata_q <= wb_dat_r;
    end
  end

  // Stores write through, a hitting line is patched under the strobes
  always_ff @(posedge clk) begin
    if (accept && req.we && hit) begin
      data_mem[req.index] <= merged;
    end else if (bus_done && fill_q) begin
      data_mem[fill_index] <= wb_dat_r;
      tag_mem[fill_index]  <= fill_tag;
    end
  end

endmodule

/* rtl/dtlb.sv */
`timescale 1ns/1ps

module dtlb (
  input  logic              clk,
  input  logic              reset,
  input  lsu_pkg::plv_t     plv,
  input  logic              we,
  input  lsu_pkg::tlb_idx_t w_idx,
  input  lsu_pkg::tag_t     w_vtag,
  input  lsu_pkg::tag_t     w_ptag,
  input  lsu_pkg::mat_t     w_mat,
  input  logic              w_v,
  input  logic              w_d,
  input  lsu_pkg::plv_t     w_plv,
  mmu_if.tlb                mmu
);

  logic [lsu_pkg::TLB_ENTRIES-1:0] ent_exist;
  logic [lsu_pkg::TLB_ENTRIES-1:0] ent_v;
  logic [lsu_pkg::TLB_ENTRIES-1:0] ent_d;
  lsu_pkg::tag_t                   ent_vtag [lsu_pkg::TLB_ENTRIES];
  lsu_pkg::tag_t                   ent_ptag [lsu_pkg::TLB_ENTRIES];
  lsu_pkg::mat_t                   ent_mat  [lsu_pkg::TLB_ENTRIES];
  lsu_pkg::plv_t                   ent_plv  [lsu_pkg::TLB_ENTRIES];
  logic                            hit;
  lsu_pkg::tlb_idx_t               hit_idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      ent_exist <= '0;
      mmu.ok    <= 1'b0;
    end else begin
      if (we) begin
        ent_exist[w_idx] <= 1'b1;
      end
      mmu.ok <= mmu.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      ent_vtag[w_idx] <= w_vtag;
      ent_ptag[w_idx] <= w_ptag;
      ent_mat[w_idx]  <= w_mat;
      ent_v[w_idx]    <= w_v;
      ent_d[w_idx]    <= w_d;
      ent_plv[w_idx]  <= w_plv;
    end
  end

  // Scanning downwards lets the lowest matching entry win
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = lsu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
      if (ent_exist[i] && ent_vtag[i] == mmu.vtag) begin
        hit     = 1'b1;
        hit_idx = lsu_pkg::tlb_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mmu.valid) begin
      mmu.ptag         <= ent_ptag[hit_idx];
      mmu.mat          <= ent_mat[hit_idx];
      mmu.page_fault   <= !hit;
      mmu.page_invalid <= hit && !ent_v[hit_idx];
      mmu.page_clean   <= hit && !ent_d[hit_idx];
      mmu.plv_fault    <= hit && (plv > ent_plv[hit_idx]);
    end
  end

endmodule

/* rtl/lsu.sv */
`timescale 1ns/1ps

module lsu (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 valid,
  output logic                 ready,
  input  lsu_pkg::word_t       addr,
  input  lsu_pkg::mem_opcode_t opcode,
  input  lsu_pkg::word_t       st_data,
  output logic                 have_excp,
  output lsu_pkg::excp_t       excp_type,
  output logic                 ok,
  output lsu_pkg::word_t       ld_data,
  mmu_if.lsu                   mmu,
  dcache_if.lsu                cache
);

  logic                 mmu_ok_reg;
  logic                 trans_ok;
  logic                 transfer;
  logic                 is_store;
  logic                 is_half;
  logic                 is_word;
  logic                 misaligned;
  lsu_pkg::offset_t     lowbit_reg;
  lsu_pkg::mem_opcode_t opcode_reg;
  logic [7:0]           load_b;
  logic [15:0]          load_h;

  assign is_store = opcode inside {lsu_pkg::ST_B, lsu_pkg::ST_H, lsu_pkg::ST_W};
  assign is_half  = opcode inside {lsu_pkg::LD_H, lsu_pkg::LD_HU, lsu_pkg::ST_H};
  assign is_word  = opcode inside {lsu_pkg::LD_W, lsu_pkg::ST_W};
  assign misaligned = (is_half && addr[0]) || (is_word && addr[1:0] != 2'b00);

  // Translation is usable when it arrives this cycle or was held from before
  assign trans_ok = mmu.ok || mmu_ok_reg;
  assign ready    = cache.addr_ok && trans_ok;
  assign transfer = valid && ready;
  assign ok       = cache.data_ok;

  // No new lookup while a result is present, so a stale result never
  // lands on the next request
  assign mmu.valid = valid && !trans_ok && !misaligned;
  assign mmu.vtag  = addr[31 -: lsu_pkg::TAG_WIDTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      mmu_ok_reg <= 1'b0;
    end else if (transfer || have_excp) begin
      mmu_ok_reg <= 1'b0;
    end else if (mmu.ok && valid) begin
      mmu_ok_reg <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (transfer) begin
      lowbit_reg <= addr[lsu_pkg::OFFSET_WIDTH-1:0];
      opcode_reg <= opcode;
    end
  end

  assign cache.valid    = valid && !have_excp && trans_ok;
  assign cache.we       = is_store;
  assign cache.tag      = mmu.ptag;
  assign cache.index    = addr[lsu_pkg::OFFSET_WIDTH +: lsu_pkg::INDEX_WIDTH];
  assign cache.offset   = addr[lsu_pkg::OFFSET_WIDTH-1:0];
  assign cache.uncached = (mmu.mat == 2'd0);

  // Store data is copied to every lane and the strobes pick the lanes
  always_comb begin
    case (opcode)
      lsu_pkg::ST_B: begin
        cache.wstrb = 4'b0001 << addr[1:0];
        cache.wdata = {4{st_data[7:0]}};
      end
      lsu_pkg::ST_H: begin
        cache.wstrb = addr[1] ? 4'b1100 : 4'b0011;
        cache.wdata = {2{st_data[15:0]}};
      end
      default: begin
        cache.wstrb = 4'b1111;
        cache.wdata = st_data;
      end
    endcase
  end

  // Alignment is checked first and does not need a translation
  always_comb begin
    have_excp = 1'b1;
    excp_type = lsu_pkg::ALE;
    if (!valid) begin
      have_excp = 1'b0;
    end else if (misaligned) begin
      excp_type = lsu_pkg::ALE;
    end else if (!trans_ok) begin
      have_excp = 1'b0;
    end else if (mmu.page_fault) begin
      excp_type = lsu_pkg::D_TLBR;
    end else if (mmu.page_invalid) begin
      if (is_store) begin
        excp_type = lsu_pkg::PIS;
      end else begin
        excp_type = lsu_pkg::PIL;
      end
    end else if (mmu.plv_fault) begin
      excp_type = lsu_pkg::PPI;
    end else if (mmu.page_clean && is_store) begin
      excp_type = lsu_pkg::PME;
    end else begin
      have_excp = 1'b0;
    end
  end

  assign load_b = cache.rdata[8*lowbit_reg +: 8];
  assign load_h = lowbit_reg[1] ? cache.rdata[31:16] : cache.rdata[15:0];

  always_comb begin
    case (opcode_reg)
      lsu_pkg::LD_B:  ld_data = {{24{load_b[7]}}, load_b};
      lsu_pkg::LD_BU: ld_data = {24'd0, load_b};
      lsu_pkg::LD_H:  ld_data = {{16{load_h[15]}}, load_h};
      lsu_pkg::LD_HU: ld_data = {16'd0, load_h};
      default:        ld_data = cache.rdata;
    endcase
  end

endmodule

/* common/mmu_if.sv */
`timescale 1ns/1ps

interface mmu_if;

  logic           valid;
  lsu_pkg::tag_t  vtag;
  logic           ok;
  lsu_pkg::tag_t  ptag;
  lsu_pkg::mat_t  mat;
  logic           page_fault;
  logic           page_invalid;
  logic           page_clean;
  logic           plv_fault;

  modport lsu (
    output valid, vtag,
    input  ok, ptag, mat, page_fault, page_invalid, page_clean, plv_fault
  );

  modport tlb (
    input  valid, vtag,
    output ok, ptag, mat, page_fault, page_invalid, page_clean, plv_fault
  );

endinterface

/* common/dcache_if.sv */
`timescale 1ns/1ps

interface dcache_if;

  logic              valid;
  logic              we;
  lsu_pkg::tag_t     tag;
  lsu_pkg::index_t   index;
  lsu_pkg::offset_t  offset;
  logic [3:0]        wstrb;
  lsu_pkg::word_t    wdata;
  logic              uncached;
  logic              addr_ok;
  logic              data_ok;
  lsu_pkg::word_t    rdata;

  modport lsu (
    output valid, we, tag, index, offset, wstrb, wdata, uncached,
    input  addr_ok, data_ok, rdata
  );

  modport cache (
    input  valid, we, tag, index, offset, wstrb, wdata, uncached,
    output addr_ok, data_ok, rdata
  );

endinterface

/* common/lsu_pkg.sv */
package lsu_pkg;

  // Address split for a 4 KiB page
  // The cache index and offset together cover exactly the page offset
  localparam int TAG_WIDTH    = 20;
  localparam int INDEX_WIDTH  = 10;
  localparam int OFFSET_WIDTH = 2;

  localparam int TLB_ENTRIES = 4;

  typedef logic [31:0]             word_t;
  typedef logic [TAG_WIDTH-1:0]    tag_t;
  typedef logic [INDEX_WIDTH-1:0]  index_t;
  typedef logic [OFFSET_WIDTH-1:0] offset_t;

  // Memory access type, 0 is strongly ordered uncached and 1 is coherent cached
  typedef logic [1:0] mat_t;

  // Privilege level, 0 is the most privileged
  typedef logic [1:0] plv_t;

  typedef logic [1:0] tlb_idx_t;

  typedef enum logic [2:0] {
    LD_B,
    LD_H,
    LD_W,
    LD_BU,
    LD_HU,
    ST_B,
    ST_H,
    ST_W
  } mem_opcode_t;

  // Listed in order of priority, highest first
  typedef enum logic [2:0] {
    ALE,
    D_TLBR,
    PIL,
    PIS,
    PPI,
    PME
  } excp_t;

endpackage
